// File: Makefile
SOURCES = project.f \
          common/fcvt_macros.svh \
          common/fcvt_pkg.sv \
          verilog/fcvt_cmd_decoder.sv \
          float_to_int/float_to_int.sv \
          int_to_float/int_to_float.sv \
          verilog/fcvt_result_collect.sv \
          verilog/fcvt_unit.sv \
          verification/fcvt_vectors.svh \
          verification/fcvt_unit_tb.sv

.PHONY: all run clean

all: run

obj_dir/Vfcvt_unit_tb: $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module fcvt_unit_tb

run: obj_dir/Vfcvt_unit_tb
	obj_dir/Vfcvt_unit_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Checks failed" sim.log || ! grep -q "All checks passed" sim.log; then \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: common/fcvt_macros.svh
// IEEE single and 32-bit two's complement only; changing these values alone does not retarget the unit

`ifndef FCVT_MACROS_SVH
`define FCVT_MACROS_SVH

// Operand and result word width
`define FCVT_WIDTH 32

// Single precision exponent bias
`define FCVT_EXP_BIAS 127

// F2I overflow word, also the most negative integer
`define FCVT_INT_MIN 32'h8000_0000

`endif

// File: common/fcvt_pkg.sv
// Types shared by the conversion unit; the float view assumes IEEE single field layout

`default_nettype none

`include "fcvt_macros.svh"

package fcvt_pkg;

    typedef enum logic {
        OP_F2I = 1'b0,  // Float to signed integer
        OP_I2F = 1'b1   // Signed integer to float
    } fcvt_op_e;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] fraction;
    } fcvt_float_t;

    // Same word seen as a float or as an integer
    typedef union packed {
        fcvt_float_t                   f;
        logic signed [`FCVT_WIDTH-1:0] i;
    } fcvt_word_u;

    typedef struct packed {
        fcvt_op_e   op;
        fcvt_word_u operand;
    } fcvt_cmd_t;

    typedef struct packed {
        logic invalid;
        logic inexact;
    } fcvt_flags_t;

    typedef struct packed {
        fcvt_op_e    op;      // Echo of the command op
        fcvt_word_u  result;
        fcvt_flags_t flags;
    } fcvt_rsp_t;

endpackage

`default_nettype wire

// File: float_to_int/float_to_int.sv
// Truncates toward zero; operand is sampled with exec_strobe_i and strobes during a conversion are ignored

`timescale 1ns/1ps
`default_nettype none

`include "fcvt_macros.svh"

module float_to_int (
    input  wire logic                 clk,
    input  wire logic                 reset_i,

    input  wire fcvt_pkg::fcvt_word_u a_value_i,
    input  wire logic                 exec_strobe_i,

    output fcvt_pkg::fcvt_word_u      z_value_o,
    output fcvt_pkg::fcvt_flags_t     flags_o,
    output logic                      done_strobe_o
    );

    typedef enum logic [1:0] {IDLE, SPECIAL_CASES, CONVERT, DONE} state_e;

    state_e state;

    logic [`FCVT_WIDTH-1:0] a_m;     // Mantissa, hidden one at the top
    logic signed [8:0]      a_e;     // Unbiased exponent
    logic                   a_s;
    logic                   sticky;  // Any one shifted out so far

    always_ff @(posedge clk) begin

        case (state)
            IDLE: begin
                // Unpack straight from the held operand
                if (exec_strobe_i) begin
                    a_m    <= {1'b1, a_value_i.f.fraction, 8'b0};
                    a_e    <= $signed({1'b0, a_value_i.f.exponent}) - `FCVT_EXP_BIAS;
                    a_s    <= a_value_i.f.sign;
                    sticky <= 1'b0;
                    state  <= SPECIAL_CASES;
                end
            end

            SPECIAL_CASES: begin
                if (a_e == -`FCVT_EXP_BIAS) begin
                    // Zero or denormal
                    z_value_o.i     <= '0;
                    flags_o.invalid <= 1'b0;
                    flags_o.inexact <= (a_m[30:8] != '0);
                    done_strobe_o   <= 1'b1;
                    state           <= DONE;
                end else if (a_e >= 31) begin
                    // NaN, infinity and overflow; -2^31 alone is exact
                    z_value_o.i     <= `FCVT_INT_MIN;
                    flags_o.invalid <= !(a_s && a_e == 31 && a_m[30:8] == '0);
                    flags_o.inexact <= 1'b0;
                    done_strobe_o   <= 1'b1;
                    state           <= DONE;
                end else begin
                    state <= CONVERT;
                end
            end

            CONVERT: begin
                if (a_e < 31 && a_m != '0) begin
                    a_m    <= a_m >> 1;
                    a_e    <= a_e + 9'sd1;
                    sticky <= sticky | a_m[0];
                end else begin
                    z_value_o.i     <= a_s ? -a_m : a_m;
                    flags_o.invalid <= 1'b0;
                    flags_o.inexact <= sticky;     // Dropped fraction
                    done_strobe_o   <= 1'b1;
                    state           <= DONE;
                end
            end

            DONE: begin
                done_strobe_o <= 1'b0;
                state         <= IDLE;
            end

            default: state <= IDLE;
        endcase

        if (reset_i) begin
            state         <= IDLE;
            done_strobe_o <= 1'b0;
        end
    end

    // Starts only reach an idle converter
    assert property (@(posedge clk) disable iff (reset_i)
        exec_strobe_i |-> (state == IDLE));

endmodule

`default_nettype wire

// File: int_to_float/int_to_float.sv
// Round to nearest even only; operand is sampled with exec_strobe_i and no denormal results occur

`timescale 1ns/1ps
`default_nettype none

`include "fcvt_macros.svh"

module int_to_float (
    input  wire logic                 clk,
    input  wire logic                 reset_i,

    input  wire fcvt_pkg::fcvt_word_u a_value_i,
    input  wire logic                 exec_strobe_i,

    output fcvt_pkg::fcvt_word_u      z_value_o,
    output fcvt_pkg::fcvt_flags_t     flags_o,
    output logic                      done_strobe_o
    );

    typedef enum logic [1:0] {IDLE, ZERO_CHECK, NORMALISE, DONE} state_e;

    state_e state;

    logic [`FCVT_WIDTH-1:0] a_m;     // Magnitude, shifted up to bit 31
    logic [7:0]             a_e;     // Biased exponent
    logic                   a_s;

    logic                   guard_bit;
    logic                   sticky_bit;
    logic                   round_up;
    logic [24:0]            rounded;   // 24 kept bits plus carry

    // Rounding of the normalised magnitude
    assign guard_bit  = a_m[7];
    assign sticky_bit = |a_m[6:0];
    assign round_up   = guard_bit & (sticky_bit | a_m[8]);   // Ties to even
    assign rounded    = {1'b0, a_m[31:8]} + {24'd0, round_up};

    always_ff @(posedge clk) begin

        case (state)
            IDLE: begin
                if (exec_strobe_i) begin
                    a_s   <= a_value_i.i[`FCVT_WIDTH-1];
                    a_m   <= a_value_i.i[`FCVT_WIDTH-1] ? -a_value_i.i : a_value_i.i;
                    a_e   <= `FCVT_EXP_BIAS + `FCVT_WIDTH - 1;
                    state <= ZERO_CHECK;
                end
            end

            ZERO_CHECK: begin
                if (a_m == '0) begin
                    z_value_o.i   <= '0;
                    flags_o       <= '0;
                    done_strobe_o <= 1'b1;
                    state         <= DONE;
                end else begin
                    state <= NORMALISE;
                end
            end

            NORMALISE: begin
                if (!a_m[`FCVT_WIDTH-1]) begin
                    a_m <= a_m << 1;
                    a_e <= a_e - 8'd1;
                end else begin
                    // Carry out of rounding leaves a zero fraction
                    z_value_o.f.sign     <= a_s;
                    z_value_o.f.exponent <= a_e + {7'd0, rounded[24]};
                    z_value_o.f.fraction <= rounded[22:0];
                    flags_o.invalid      <= 1'b0;
                    flags_o.inexact      <= guard_bit | sticky_bit;
                    done_strobe_o        <= 1'b1;
                    state                <= DONE;
                end
            end

            DONE: begin
                done_strobe_o <= 1'b0;
                state         <= IDLE;
            end

            default: state <= IDLE;
        endcase

        if (reset_i) begin
            state         <= IDLE;
            done_strobe_o <= 1'b0;
        end
    end

    // At most 31 shifts down from 158
    assert property (@(posedge clk) disable iff (reset_i)
        (state == NORMALISE) |-> (a_e >= `FCVT_EXP_BIAS));

endmodule

`default_nettype wire

// File: project.f
+incdir+common
+incdir+verification
common/fcvt_pkg.sv
verilog/fcvt_cmd_decoder.sv
float_to_int/float_to_int.sv
int_to_float/int_to_float.sv
verilog/fcvt_result_collect.sv
verilog/fcvt_unit.sv
verification/fcvt_unit_tb.sv

// File: verification/fcvt_vectors.svh
// Directed vectors only; expected values assume truncation for F2I and ties to even for I2F

`ifndef FCVT_VECTORS_SVH
`define FCVT_VECTORS_SVH

// Columns: name, op, operand, expected result, expected flags {invalid, inexact}
task automatic load_vectors();
    add_vector("f2i_one",          OP_F2I, 32'h3f80_0000, 32'h0000_0001, 2'b00);
    add_vector("f2i_minus_one",    OP_F2I, 32'hbf80_0000, 32'hffff_ffff, 2'b00);
    add_vector("f2i_minus_2_5",    OP_F2I, 32'hc020_0000, 32'hffff_fffe, 2'b01);
    add_vector("f2i_12345_75",     OP_F2I, 32'h4640_e700, 32'h0000_3039, 2'b01);
    add_vector("f2i_two_pow_30",   OP_F2I, 32'h4e80_0000, 32'h4000_0000, 2'b00);
    add_vector("f2i_plus_zero",    OP_F2I, 32'h0000_0000, 32'h0000_0000, 2'b00);
    add_vector("f2i_minus_zero",   OP_F2I, 32'h8000_0000, 32'h0000_0000, 2'b00);
    add_vector("f2i_denormal",     OP_F2I, 32'h0000_0001, 32'h0000_0000, 2'b01);
    add_vector("f2i_nan",          OP_F2I, 32'h7fc0_0000, 32'h8000_0000, 2'b10);
    add_vector("f2i_plus_inf",     OP_F2I, 32'h7f80_0000, 32'h8000_0000, 2'b10);
    add_vector("f2i_minus_inf",    OP_F2I, 32'hff80_0000, 32'h8000_0000, 2'b10);
    add_vector("f2i_two_pow_31",   OP_F2I, 32'h4f00_0000, 32'h8000_0000, 2'b10);
    add_vector("f2i_int_min",      OP_F2I, 32'hcf00_0000, 32'h8000_0000, 2'b00);  // Exact
    add_vector("i2f_zero",         OP_I2F, 32'h0000_0000, 32'h0000_0000, 2'b00);
    add_vector("i2f_one",          OP_I2F, 32'h0000_0001, 32'h3f80_0000, 2'b00);
    add_vector("i2f_minus_one",    OP_I2F, 32'hffff_ffff, 32'hbf80_0000, 2'b00);
    add_vector("i2f_int_min",      OP_I2F, 32'h8000_0000, 32'hcf00_0000, 2'b00);
    add_vector("i2f_12345",        OP_I2F, 32'h0000_3039, 32'h4640_e400, 2'b00);
    // Ties, one stays even and one rounds up to even
    add_vector("i2f_16777217",     OP_I2F, 32'h0100_0001, 32'h4b80_0000, 2'b01);
    add_vector("i2f_16777219",     OP_I2F, 32'h0100_0003, 32'h4b80_0002, 2'b01);
endtask

`endif

// File: verification/fcvt_unit_tb.sv
// Commands are strobed only while busy_o is low, except for the deliberate drop check

`timescale 1ns/1ps
`default_nettype none

module fcvt_unit_tb;

    import fcvt_pkg::*;

    localparam int          CLK_HALF       = 20;     // 40 ns period
    localparam int          RESET_CYCLES   = 16;
    localparam logic [31:0] LFSR_SEED      = 32'h4dd1_3601;
    localparam int          ROUND_TRIPS    = 24;
    localparam int          RANDOM_CMDS    = 2 * ROUND_TRIPS + 2;  // Plus the drop check pair
    localparam int          CYCLES_PER_CMD = 48;
    localparam int          TIMEOUT_MARGIN = 32;
    localparam int          QUIET_CYCLES   = 40;

    typedef struct {
        string       name;
        fcvt_cmd_t   cmd;
        fcvt_word_u  exp_result;
        fcvt_flags_t exp_flags;
    } vector_t;

    logic        clk;
    logic        reset_i;
    logic        cmd_valid_i;
    fcvt_cmd_t   cmd_i;
    logic        rsp_valid_o;
    fcvt_rsp_t   rsp_o;
    logic        busy_o;

    vector_t     vectors[$];
    logic [31:0] lfsr_state;
    int          mismatch_count;
    int          failure_count;
    int          cycle_count;
    int          cycle_limit;

    fcvt_unit dut0 (
        .clk         (clk),
        .reset_i     (reset_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o),
        .busy_o      (busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    function automatic void add_vector(input string name, input fcvt_op_e op,
            input logic [31:0] operand, input logic [31:0] result, input fcvt_flags_t flags);
        vector_t v;
        v.name          = name;
        v.cmd.op        = op;
        v.cmd.operand.i = operand;
        v.exp_result.i  = result;
        v.exp_flags     = flags;
        vectors.push_back(v);
    endfunction

    `include "fcvt_vectors.svh"

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic take_random_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int k = 0; k < count; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits       = {bits[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_word(input string name, input fcvt_word_u expected,
            input fcvt_word_u actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH %s result: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    task automatic check_flags(input string name, input fcvt_flags_t expected,
            input fcvt_flags_t actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH %s flags: expected %02b, actual %02b", name, expected, actual);
        end
    endtask

    task automatic check_op(input string name, input fcvt_op_e expected, input fcvt_op_e actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH %s op: expected %s, actual %s", name, expected.name(),
                     actual.name());
        end
    endtask

    task automatic check_idle();
        if (busy_o !== 1'b0 || rsp_valid_o !== 1'b0) begin
            failure_count++;
            $display("busy_o or rsp_valid_o was not low during or right after reset");
        end
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (busy_o)
            @(negedge clk);
    endtask

    task automatic send_command(input fcvt_cmd_t cmd);
        @(posedge clk);
        cmd_valid_i <= 1'b1;
        cmd_i       <= cmd;
        @(posedge clk);
        cmd_valid_i <= 1'b0;
    endtask

    task automatic wait_response(output fcvt_rsp_t rsp);
        @(negedge clk);
        while (!rsp_valid_o)
            @(negedge clk);
        rsp = rsp_o;
    endtask

    task automatic run_command(input fcvt_cmd_t cmd, output fcvt_rsp_t rsp);
        wait_idle();
        send_command(cmd);
        wait_response(rsp);
    endtask

    // Watchdog
    initial begin
        cycle_count = 0;
        while (cycle_limit == 0 || cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles waiting for the DUT", cycle_count);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        $display("Checks failed");
        $finish;
    end

    initial begin
        fcvt_rsp_t   rsp;
        fcvt_cmd_t   cmd;
        fcvt_word_u  expected_word;
        logic [31:0] bits;
        string       name;
        int          extra_responses;

        reset_i        = 1'b1;
        cmd_valid_i    = 1'b0;
        cmd_i          = '0;
        lfsr_state     = LFSR_SEED;
        mismatch_count = 0;
        failure_count  = 0;
        load_vectors();
        cycle_limit = (vectors.size() + RANDOM_CMDS) * CYCLES_PER_CMD + TIMEOUT_MARGIN;

        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            if (i == RESET_CYCLES - 1)
                reset_i <= 1'b0;
            @(negedge clk);
            check_idle();
        end
        @(negedge clk);
        check_idle();                            // First cycle out of reset

        for (int n = 0; n < vectors.size(); n++) begin
            run_command(vectors[n].cmd, rsp);
            check_op(vectors[n].name, vectors[n].cmd.op, rsp.op);
            check_word(vectors[n].name, vectors[n].exp_result, rsp.result);
            check_flags(vectors[n].name, vectors[n].exp_flags, rsp.flags);
        end

        // 24-bit values convert exactly both ways
        for (int n = 0; n < ROUND_TRIPS; n++) begin
            take_random_bits(24, bits);
            expected_word.i = {{8{bits[23]}}, bits[23:0]};
            name            = $sformatf("round_trip_%0d", n);
            cmd.op          = OP_I2F;
            cmd.operand     = expected_word;
            run_command(cmd, rsp);
            check_op(name, OP_I2F, rsp.op);
            check_flags(name, '0, rsp.flags);
            cmd.op      = OP_F2I;
            cmd.operand = rsp.result;
            run_command(cmd, rsp);
            check_op(name, OP_F2I, rsp.op);
            check_word(name, expected_word, rsp.result);
            check_flags(name, '0, rsp.flags);
        end

        // 1.0 takes a long F2I path, so the second strobe lands mid-conversion
        wait_idle();
        cmd.op          = OP_F2I;
        cmd.operand.i   = 32'h3f80_0000;
        send_command(cmd);
        @(negedge clk);
        if (!busy_o) begin
            failure_count++;
            $display("busy_o did not rise after an accepted command");
        end
        cmd.op        = OP_I2F;
        cmd.operand.i = 32'h0000_0001;
        send_command(cmd);
        wait_response(rsp);
        expected_word.i = 32'h0000_0001;
        check_op("dropped_cmd", OP_F2I, rsp.op);
        check_word("dropped_cmd", expected_word, rsp.result);
        check_flags("dropped_cmd", '0, rsp.flags);
        extra_responses = 0;
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            if (rsp_valid_o)
                extra_responses++;
        end
        if (extra_responses != 0) begin
            failure_count++;
            $display("A command strobed while busy produced %0d extra responses",
                     extra_responses);
        end
        if (busy_o) begin
            failure_count++;
            $display("busy_o stayed high after the response");
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/fcvt_cmd_decoder.sv
// One command in flight; strobes arriving while busy_o is high are dropped without any response

`timescale 1ns/1ps
`default_nettype none

module fcvt_cmd_decoder (
    input  wire logic                clk,
    input  wire logic                reset_i,

    input  wire logic                cmd_valid_i,
    input  wire fcvt_pkg::fcvt_cmd_t cmd_i,
    input  wire logic                rsp_valid_i,

    output fcvt_pkg::fcvt_word_u     operand_o,
    output logic                     f2i_start_o,
    output logic                     i2f_start_o,
    output logic                     busy_o
    );

    import fcvt_pkg::*;

    logic accept;

    assign accept = cmd_valid_i & ~busy_o;

    // Operand held until the next accepted command
    always_ff @(posedge clk) begin
        if (accept)
            operand_o <= cmd_i.operand;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            f2i_start_o <= 1'b0;
            i2f_start_o <= 1'b0;
            busy_o      <= 1'b0;
        end else begin
            f2i_start_o <= accept && (cmd_i.op == OP_F2I);
            i2f_start_o <= accept && (cmd_i.op == OP_I2F);

            if (accept)
                busy_o <= 1'b1;
            else if (rsp_valid_i)
                busy_o <= 1'b0;      // Free again the cycle after the response
        end
    end

    // Every response closes a command still in flight
    assert property (@(posedge clk) disable iff (reset_i)
        rsp_valid_i |-> busy_o);

endmodule

`default_nettype wire

// File: verilog/fcvt_result_collect.sv
// Expects at most one converter to finish per cycle; rsp_o holds until the next response

`timescale 1ns/1ps
`default_nettype none

module fcvt_result_collect (
    input  wire logic                  clk,
    input  wire logic                  reset_i,

    input  wire logic                  f2i_done_i,
    input  wire logic                  i2f_done_i,
    input  wire fcvt_pkg::fcvt_word_u  f2i_result_i,
    input  wire fcvt_pkg::fcvt_word_u  i2f_result_i,
    input  wire fcvt_pkg::fcvt_flags_t f2i_flags_i,
    input  wire fcvt_pkg::fcvt_flags_t i2f_flags_i,

    output logic                       rsp_valid_o,
    output fcvt_pkg::fcvt_rsp_t        rsp_o
    );

    import fcvt_pkg::*;

    always_ff @(posedge clk) begin
        if (reset_i)
            rsp_valid_o <= 1'b0;
        else
            rsp_valid_o <= f2i_done_i | i2f_done_i;
    end

    // Op comes from whichever converter finished
    always_ff @(posedge clk) begin
        if (f2i_done_i) begin
            rsp_o.op     <= OP_F2I;
            rsp_o.result <= f2i_result_i;
            rsp_o.flags  <= f2i_flags_i;
        end else if (i2f_done_i) begin
            rsp_o.op     <= OP_I2F;
            rsp_o.result <= i2f_result_i;
            rsp_o.flags  <= i2f_flags_i;
        end
    end

    // Only one converter runs at a time
    assert property (@(posedge clk) disable iff (reset_i)
        !(f2i_done_i && i2f_done_i));

endmodule

`default_nettype wire

// File: verilog/fcvt_unit.sv
// Single outstanding command with no back-pressure; host watches busy_o before strobing

`timescale 1ns/1ps
`default_nettype none

module fcvt_unit (
    input  wire logic                clk,
    input  wire logic                reset_i,

    input  wire logic                cmd_valid_i,
    input  wire fcvt_pkg::fcvt_cmd_t cmd_i,

    output logic                     rsp_valid_o,
    output fcvt_pkg::fcvt_rsp_t      rsp_o,
    output logic                     busy_o
    );

    import fcvt_pkg::*;

    fcvt_word_u  operand;
    logic        f2i_start;
    logic        i2f_start;
    logic        f2i_done;
    logic        i2f_done;
    fcvt_word_u  f2i_result;
    fcvt_word_u  i2f_result;
    fcvt_flags_t f2i_flags;
    fcvt_flags_t i2f_flags;

    fcvt_cmd_decoder decoder0 (
        .clk          (clk),
        .reset_i      (reset_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_i        (cmd_i),
        .rsp_valid_i  (rsp_valid_o),
        .operand_o    (operand),
        .f2i_start_o  (f2i_start),
        .i2f_start_o  (i2f_start),
        .busy_o       (busy_o)
    );

    float_to_int f2i0 (
        .clk           (clk),
        .reset_i       (reset_i),
        .a_value_i     (operand),
        .exec_strobe_i (f2i_start),
        .z_value_o     (f2i_result),
        .flags_o       (f2i_flags),
        .done_strobe_o (f2i_done)
    );

    int_to_float i2f0 (
        .clk           (clk),
        .reset_i       (reset_i),
        .a_value_i     (operand),
        .exec_strobe_i (i2f_start),
        .z_value_o     (i2f_result),
        .flags_o       (i2f_flags),
        .done_strobe_o (i2f_done)
    );

    fcvt_result_collect collect0 (
        .clk          (clk),
        .reset_i      (reset_i),
        .f2i_done_i   (f2i_done),
        .i2f_done_i   (i2f_done),
        .f2i_result_i (f2i_result),
        .i2f_result_i (i2f_result),
        .f2i_flags_i  (f2i_flags),
        .i2f_flags_i  (i2f_flags),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_o        (rsp_o)
    );

endmodule

`default_nettype wire
